// File: verilog/cpu_pkg.sv
package cpu_pkg;

    ////////////////////////////////////////
    // widths
    ////////////////////////////////////////

    typedef logic [31:0] word_t;     // register contents, operands, results
    typedef logic [4:0]  reg_addr_t; // gpr number
    typedef logic [31:0] inst_t;     // raw instruction word
    typedef logic [5:0]  opcode_t;   // inst[31:26]
    typedef logic [5:0]  funct_t;    // inst[5:0], special only

    ////////////////////////////////////////
    // encodings
    ////////////////////////////////////////

    // primary opcodes
    localparam opcode_t OP_SPECIAL = 6'b000000; // r-type, look at funct
    localparam opcode_t OP_ANDI    = 6'b001100;
    localparam opcode_t OP_ORI     = 6'b001101;
    localparam opcode_t OP_XORI    = 6'b001110;
    localparam opcode_t OP_LUI     = 6'b001111;
    localparam opcode_t OP_PREF    = 6'b110011; // hint only, no effect here

    // special function codes
    localparam funct_t FN_AND  = 6'b100100;
    localparam funct_t FN_OR   = 6'b100101;
    localparam funct_t FN_XOR  = 6'b100110;
    localparam funct_t FN_NOR  = 6'b100111;
    localparam funct_t FN_SLL  = 6'b000000; // also nop / ssnop with rd 0
    localparam funct_t FN_SRL  = 6'b000010;
    localparam funct_t FN_SRA  = 6'b000011;
    localparam funct_t FN_SLLV = 6'b000100;
    localparam funct_t FN_SRLV = 6'b000110;
    localparam funct_t FN_SRAV = 6'b000111;
    localparam funct_t FN_SYNC = 6'b001111;

    // alu operation, fixed and variable shifts share a code
    typedef enum logic [3:0] {
        ALU_NOP = 4'd0,
        ALU_AND = 4'd1,
        ALU_OR  = 4'd2,
        ALU_XOR = 4'd3,
        ALU_NOR = 4'd4,
        ALU_LUI = 4'd5, // passes src2
        ALU_SLL = 4'd6,
        ALU_SRL = 4'd7,
        ALU_SRA = 4'd8
    } alu_op_e;

    ////////////////////////////////////////
    // pipeline bundles
    ////////////////////////////////////////

    typedef struct packed {
        alu_op_e   alu_op;
        logic      rd1_en;   // src1 from gpr, else imm
        reg_addr_t rd1_addr;
        logic      rd2_en;   // src2 from gpr, else imm
        reg_addr_t rd2_addr;
        logic      wr_en;
        reg_addr_t wr_addr;
        word_t     imm;
    } dec_t;

    typedef struct packed {
        alu_op_e   alu_op;
        word_t     src1;
        word_t     src2;
        logic      wr_en;
        reg_addr_t wr_addr;
    } id_ex_t;

    // one register write, used for forwards and write-back
    typedef struct packed {
        logic      wr_en;
        reg_addr_t wr_addr;
        word_t     data;
    } wb_t;

endpackage

// File: verilog/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder import cpu_pkg::*;
(
    input  inst_t i_inst,
    output dec_t  o_dec
);

    ////////////////////////////////////////
    // instruction fields
    ////////////////////////////////////////

    opcode_t     op;
    funct_t      funct;
    reg_addr_t   rs;
    reg_addr_t   rt;
    reg_addr_t   rd;
    logic [4:0]  sa;
    logic [15:0] imm16;

    assign op    = i_inst[31:26];
    assign rs    = i_inst[25:21];
    assign rt    = i_inst[20:16];
    assign rd    = i_inst[15:11];
    assign sa    = i_inst[10:6];
    assign funct = i_inst[5:0];
    assign imm16 = i_inst[15:0];

    // special funct to alu op
    function automatic alu_op_e fn_to_op(input funct_t fn);
        case (fn)
            FN_AND:          return ALU_AND;
            FN_OR:           return ALU_OR;
            FN_XOR:          return ALU_XOR;
            FN_NOR:          return ALU_NOR;
            FN_SLL, FN_SLLV: return ALU_SLL;
            FN_SRL, FN_SRLV: return ALU_SRL;
            FN_SRA, FN_SRAV: return ALU_SRA;
            default:         return ALU_NOP;
        endcase
    endfunction

    ////////////////////////////////////////
    // decode
    ////////////////////////////////////////

    always_comb
    begin
        // bubble unless a case below says otherwise
        o_dec          = '0;
        o_dec.alu_op   = ALU_NOP;

        case (op)
            OP_SPECIAL:
            begin
                case (funct)
                    FN_AND, FN_OR, FN_XOR, FN_NOR:
                    begin
                        o_dec.alu_op   = fn_to_op(funct);
                        o_dec.rd1_en   = 1'b1; // rs
                        o_dec.rd1_addr = rs;
                        o_dec.rd2_en   = 1'b1; // rt
                        o_dec.rd2_addr = rt;
                        o_dec.wr_en    = 1'b1;
                        o_dec.wr_addr  = rd;
                    end
                    FN_SLL, FN_SRL, FN_SRA:
                    begin
                        o_dec.alu_op   = fn_to_op(funct);
                        o_dec.rd1_en   = 1'b1; // value to shift
                        o_dec.rd1_addr = rt;
                        o_dec.imm      = {27'b0, sa}; // amount rides in src2
                        o_dec.wr_en    = 1'b1;
                        o_dec.wr_addr  = rd;
                    end
                    FN_SLLV, FN_SRLV, FN_SRAV:
                    begin
                        o_dec.alu_op   = fn_to_op(funct);
                        o_dec.rd1_en   = 1'b1;
                        o_dec.rd1_addr = rt;
                        o_dec.rd2_en   = 1'b1; // amount from rs, ex keeps bits 4..0
                        o_dec.rd2_addr = rs;
                        o_dec.wr_en    = 1'b1;
                        o_dec.wr_addr  = rd;
                    end
                    FN_SYNC: ;  // ordering only, nothing to do in this core
                    default: ;  // unknown funct -> bubble
                endcase
            end
            OP_ANDI, OP_ORI, OP_XORI:
            begin
                case (op)
                    OP_ANDI: o_dec.alu_op = ALU_AND;
                    OP_ORI:  o_dec.alu_op = ALU_OR;
                    default: o_dec.alu_op = ALU_XOR;
                endcase
                o_dec.rd1_en   = 1'b1;
                o_dec.rd1_addr = rs;
                o_dec.imm      = {16'h0000, imm16}; // zero extended
                o_dec.wr_en    = 1'b1;
                o_dec.wr_addr  = rt;
            end
            OP_LUI:
            begin
                o_dec.alu_op  = ALU_LUI;
                o_dec.imm     = {imm16, 16'h0000}; // both srcs get this
                o_dec.wr_en   = 1'b1;
                o_dec.wr_addr = rt;
            end
            OP_PREF: ;      // prefetch hint, no cache here
            default: ;      // unknown opcode
        endcase

        // r0 is hardwired, covers nop and ssnop too
        if (o_dec.wr_addr == '0)
        begin
            o_dec.wr_en  = 1'b0;
            o_dec.alu_op = ALU_NOP;
        end
    end

endmodule

// File: verilog/id_stage.sv
`timescale 1ns/1ps

module id_stage import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  inst_t     i_inst,
    output reg_addr_t o_rd1_addr,
    output reg_addr_t o_rd2_addr,
    input  word_t     i_rd1_data,
    input  word_t     i_rd2_data,
    input  wb_t       i_ex_fwd,  // result being computed in ex
    input  wb_t       i_mem_fwd, // result sitting in the mem slot
    output id_ex_t    o_id_ex
);

    dec_t  dec;
    word_t src1;
    word_t src2;

    inst_decoder u_dec
    (
        .i_inst (i_inst),
        .o_dec  (dec)
    );

    assign o_rd1_addr = dec.rd1_addr;
    assign o_rd2_addr = dec.rd2_addr;

    ////////////////////////////////////////
    // operand select with forwarding
    ////////////////////////////////////////

    // imm if no read, else newest copy of the register
    function automatic word_t pick_src(
        input logic      en,
        input reg_addr_t addr,
        input word_t     rf_data,
        input word_t     imm,
        input wb_t       ex_fwd,
        input wb_t       mem_fwd
    );
        if (!en)
            return imm;
        else if (ex_fwd.wr_en && ex_fwd.wr_addr == addr)
            return ex_fwd.data;  // previous instruction, highest priority
        else if (mem_fwd.wr_en && mem_fwd.wr_addr == addr)
            return mem_fwd.data; // two back, not yet in the regfile
        else
            return rf_data;
    endfunction

    assign src1 = pick_src(dec.rd1_en, dec.rd1_addr, i_rd1_data, dec.imm, i_ex_fwd, i_mem_fwd);
    assign src2 = pick_src(dec.rd2_en, dec.rd2_addr, i_rd2_data, dec.imm, i_ex_fwd, i_mem_fwd);

    ////////////////////////////////////////
    // id/ex register
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        o_id_ex.src1    <= src1;
        o_id_ex.src2    <= src2;
        o_id_ex.wr_addr <= dec.wr_addr;
        if (rst)
        begin
            o_id_ex.wr_en  <= 1'b0;
            o_id_ex.alu_op <= ALU_NOP; // ex result is 0 while in reset
        end
        else
        begin
            o_id_ex.wr_en  <= dec.wr_en;
            o_id_ex.alu_op <= dec.alu_op;
        end
    end

endmodule

// File: verilog/ex_stage.sv
`timescale 1ns/1ps

module ex_stage import cpu_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  id_ex_t i_id_ex,
    output wb_t    o_ex_fwd, // same cycle, for id forwarding
    output wb_t    o_mem     // ex/mem register, also the write-back
);

    logic [4:0] shamt;
    word_t      result;

    assign shamt = i_id_ex.src2[4:0]; // sa or rs[4:0], upper bits ignored

    ////////////////////////////////////////
    // alu
    ////////////////////////////////////////

    always_comb
    begin
        case (i_id_ex.alu_op)
            ALU_AND: result = i_id_ex.src1 & i_id_ex.src2;
            ALU_OR:  result = i_id_ex.src1 | i_id_ex.src2;
            ALU_XOR: result = i_id_ex.src1 ^ i_id_ex.src2;
            ALU_NOR: result = ~(i_id_ex.src1 | i_id_ex.src2);
            ALU_LUI: result = i_id_ex.src2;          // already shifted by decoder
            ALU_SLL: result = i_id_ex.src1 << shamt;
            ALU_SRL: result = i_id_ex.src1 >> shamt; // zero fill
            ALU_SRA: result = word_t'($signed(i_id_ex.src1) >>> shamt); // sign fill
            default: result = '0;                    // bubble
        endcase
    end

    always_comb
    begin
        o_ex_fwd.wr_en   = i_id_ex.wr_en;
        o_ex_fwd.wr_addr = i_id_ex.wr_addr;
        o_ex_fwd.data    = result;
    end

    ////////////////////////////////////////
    // ex/mem register
    ////////////////////////////////////////

    // mem slot holds the result one more cycle
    always_ff @(posedge clk)
    begin
        o_mem.wr_addr <= o_ex_fwd.wr_addr;
        o_mem.data    <= o_ex_fwd.data;
        if (rst)
            o_mem.wr_en <= 1'b0;
        else
            o_mem.wr_en <= o_ex_fwd.wr_en;
    end

endmodule

// File: verilog/regfile.sv
`timescale 1ns/1ps

module regfile import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  reg_addr_t i_rd1_addr,
    input  reg_addr_t i_rd2_addr,
    output word_t     o_rd1_data,
    output word_t     o_rd2_data,
    input  wb_t       i_wr       // from the mem slot
);

    word_t regs [32];

    // write at the edge that ends the mem slot
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0; // all gprs start at zero
        end
        else if (i_wr.wr_en && i_wr.wr_addr != '0) // r0 stays 0
        begin
            regs[i_wr.wr_addr] <= i_wr.data;
        end
    end

    // async reads, same-cycle write is covered by mem forward in id
    assign o_rd1_data = regs[i_rd1_addr];
    assign o_rd2_data = regs[i_rd2_addr];

endmodule

// File: verilog/cpu_core.sv
`timescale 1ns/1ps

module cpu_core import cpu_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  inst_t i_inst, // one word per cycle, no stall
    output wb_t   o_wb    // two cycles after i_inst
);

    reg_addr_t rd1_addr;
    reg_addr_t rd2_addr;
    word_t     rd1_data;
    word_t     rd2_data;
    wb_t       ex_fwd;
    id_ex_t    id_ex;

    ////////////////////////////////////////
    // id -> ex -> mem/wb
    ////////////////////////////////////////

    id_stage u_id
    (
        .clk        (clk),
        .rst        (rst),
        .i_inst     (i_inst),
        .o_rd1_addr (rd1_addr),
        .o_rd2_addr (rd2_addr),
        .i_rd1_data (rd1_data),
        .i_rd2_data (rd2_data),
        .i_ex_fwd   (ex_fwd),
        .i_mem_fwd  (o_wb),     // mem slot doubles as forward source
        .o_id_ex    (id_ex)
    );

    ex_stage u_ex
    (
        .clk      (clk),
        .rst      (rst),
        .i_id_ex  (id_ex),
        .o_ex_fwd (ex_fwd),
        .o_mem    (o_wb)
    );

    regfile u_rf
    (
        .clk        (clk),
        .rst        (rst),
        .i_rd1_addr (rd1_addr),
        .i_rd2_addr (rd2_addr),
        .o_rd1_data (rd1_data),
        .o_rd2_data (rd2_data),
        .i_wr       (o_wb)      // write-back port
    );

endmodule

// File: testbench/cpu_core_sva.sv
`timescale 1ns/1ps

module cpu_core_sva import cpu_pkg::*;
(
    input logic clk,
    input logic rst,
    input wb_t  i_wb    // dut write-back, same bundle the regfile sees
);

    ////////////////////////////////////////
    // write-back port rules
    ////////////////////////////////////////

    // reset empties the mem slot one edge later
    a_wb_off_after_rst: assert property (@(posedge clk) rst |=> !i_wb.wr_en)
        else $error("write-back enabled in the cycle after reset");

    // r0 is hardwired, decoder must have dropped it
    a_no_r0_write: assert property (@(posedge clk) disable iff (rst)
        i_wb.wr_en |-> i_wb.wr_addr != '0)
        else $error("write-back targets register 0");

    a_wb_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(i_wb))
        else $error("write-back carries x or z bits");

endmodule

// attach to every core instance
bind cpu_core cpu_core_sva u_sva
(
    .clk  (clk),
    .rst  (rst),
    .i_wb (o_wb)
);

// File: testbench/tb_core.sv
`timescale 1ns/1ps

module tb_core import cpu_pkg::*;
();

    typedef struct packed {
        inst_t inst;
        wb_t   exp;    // write-back seen two edges after the row is driven
    } row_t;

    localparam int RESET_CYCLES = 8;

    logic  clk;
    logic  rst;
    inst_t inst;
    wb_t   wb;
    row_t  rows [$];
    int    cycle_count = 0;
    int    cycle_limit = 0;

    cpu_core dut
    (
        .clk    (clk),
        .rst    (rst),
        .i_inst (inst),
        .o_wb   (wb)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk; // 4 ns period
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    function automatic inst_t r_format(input reg_addr_t rs, input reg_addr_t rt,
                                       input reg_addr_t rd, input logic [4:0] sa,
                                       input funct_t fn);
        return {OP_SPECIAL, rs, rt, rd, sa, fn};
    endfunction

    function automatic inst_t i_format(input opcode_t op, input reg_addr_t rs,
                                       input reg_addr_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic add_row(input inst_t word, input logic en, input reg_addr_t addr,
                           input word_t data);
        row_t r;
        r.inst        = word;
        r.exp.wr_en   = en;
        r.exp.wr_addr = addr;
        r.exp.data    = data;
        rows.push_back(r);
    endtask

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    // addr and data only matter when a write is expected
    task automatic check_wb(input int n, input wb_t exp);
        assert (wb.wr_en === exp.wr_en)
        else
            stop_on_error($sformatf("mismatch at %0t: row %0d wr_en %b, expected %b",
                                    $time, n, wb.wr_en, exp.wr_en));
        if (exp.wr_en)
        begin
            assert (wb.wr_addr === exp.wr_addr && wb.data === exp.data)
            else
                stop_on_error($sformatf("mismatch at %0t: row %0d wrote r%0d=%h, expected r%0d=%h",
                                        $time, n, wb.wr_addr, wb.data, exp.wr_addr, exp.data));
        end
    endtask

    // hung run guard
    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit)
            stop_on_error($sformatf("timeout: run still going after %0d cycles", cycle_count));
    end

    ////////////////////////////////////////
    // stimulus and checks
    ////////////////////////////////////////

    initial
    begin
        rst  = 1'b1;
        inst = i_format(OP_ORI, 5'd0, 5'd31, 16'hdead); // live write held off by reset

        // immediates with a constant built through ex and mem forward
        add_row(i_format(OP_LUI,  5'd0, 5'd1, 16'h1234), 1'b1, 5'd1, 32'h1234_0000);
        add_row(i_format(OP_ORI,  5'd1, 5'd1, 16'h5678), 1'b1, 5'd1, 32'h1234_5678);
        add_row(i_format(OP_ANDI, 5'd1, 5'd2, 16'hff0f), 1'b1, 5'd2, 32'h0000_5608);
        add_row(i_format(OP_XORI, 5'd1, 5'd3, 16'hffff), 1'b1, 5'd3, 32'h1234_a987);
        add_row(i_format(OP_ORI,  5'd0, 5'd4, 16'h00f0), 1'b1, 5'd4, 32'h0000_00f0);
        add_row(i_format(OP_LUI,  5'd0, 5'd5, 16'hf0f0), 1'b1, 5'd5, 32'hf0f0_0000);
        // r-type logic
        add_row(r_format(5'd1, 5'd3, 5'd6, 5'd0, FN_AND), 1'b1, 5'd6, 32'h1234_0000);
        add_row(r_format(5'd2, 5'd4, 5'd7, 5'd0, FN_OR),  1'b1, 5'd7, 32'h0000_56f8);
        add_row(r_format(5'd1, 5'd5, 5'd8, 5'd0, FN_XOR), 1'b1, 5'd8, 32'he2c4_5678);
        add_row(r_format(5'd4, 5'd0, 5'd9, 5'd0, FN_NOR), 1'b1, 5'd9, 32'hffff_ff0f);
        // shifts of negative r8 where amount 0xffe3 keeps only 3
        add_row(r_format(5'd0, 5'd8, 5'd11, 5'd4, FN_SLL), 1'b1, 5'd11, 32'h2c45_6780);
        add_row(r_format(5'd0, 5'd8, 5'd12, 5'd8, FN_SRL), 1'b1, 5'd12, 32'h00e2_c456);
        add_row(r_format(5'd0, 5'd8, 5'd13, 5'd8, FN_SRA), 1'b1, 5'd13, 32'hffe2_c456);
        add_row(i_format(OP_ORI, 5'd0, 5'd14, 16'hffe3), 1'b1, 5'd14, 32'h0000_ffe3);
        add_row(r_format(5'd14, 5'd8, 5'd15, 5'd0, FN_SLLV), 1'b1, 5'd15, 32'h1622_b3c0);
        add_row(r_format(5'd14, 5'd8, 5'd16, 5'd0, FN_SRLV), 1'b1, 5'd16, 32'h1c58_8acf);
        add_row(r_format(5'd14, 5'd8, 5'd17, 5'd0, FN_SRAV), 1'b1, 5'd17, 32'hfc58_8acf);
        // two writers of r18 in flight and the younger wins
        add_row(i_format(OP_ORI, 5'd0, 5'd18, 16'h1111), 1'b1, 5'd18, 32'h0000_1111);
        add_row(i_format(OP_ORI, 5'd0, 5'd18, 16'h2222), 1'b1, 5'd18, 32'h0000_2222);
        add_row(r_format(5'd18, 5'd0, 5'd19, 5'd0, FN_OR), 1'b1, 5'd19, 32'h0000_2222);
        add_row(i_format(OP_ORI, 5'd0, 5'd20, 16'h000f), 1'b1, 5'd20, 32'h0000_000f);
        add_row(r_format(5'd20, 5'd18, 5'd21, 5'd0, FN_XOR), 1'b1, 5'd21, 32'h0000_222d);
        add_row(r_format(5'd21, 5'd20, 5'd22, 5'd0, FN_NOR), 1'b1, 5'd22, 32'hffff_ddd0);
        // bubbles for nop, ssnop, sync, pref, bad opcode, bad funct and r0 dest
        add_row(32'h0000_0000, 1'b0, 5'd0, '0);
        add_row(r_format(5'd0, 5'd0, 5'd0, 5'd1, FN_SLL), 1'b0, 5'd0, '0);
        add_row(r_format(5'd0, 5'd0, 5'd0, 5'd0, FN_SYNC), 1'b0, 5'd0, '0);
        add_row(i_format(OP_PREF, 5'd1, 5'd0, 16'h0010), 1'b0, 5'd0, '0);
        add_row(i_format(6'h3f, 5'd1, 5'd2, 16'h1234), 1'b0, 5'd0, '0);
        add_row(r_format(5'd1, 5'd2, 5'd5, 5'd0, 6'h3e), 1'b0, 5'd0, '0);
        add_row(i_format(OP_ORI, 5'd1, 5'd0, 16'hffff), 1'b0, 5'd0, '0);
        // r0 still reads 0 and r2 is untouched by the bad opcode
        add_row(r_format(5'd0, 5'd0, 5'd23, 5'd0, FN_OR),  1'b1, 5'd23, 32'h0000_0000);
        add_row(r_format(5'd0, 5'd1, 5'd24, 5'd0, FN_XOR), 1'b1, 5'd24, 32'h1234_5678);
        add_row(r_format(5'd2, 5'd0, 5'd25, 5'd0, FN_OR),  1'b1, 5'd25, 32'h0000_5608);

        cycle_limit = rows.size() + RESET_CYCLES + 20;

        for (int c = 0; c < RESET_CYCLES; c++)
        begin
            @(posedge clk);
            #1;
            assert (wb.wr_en === 1'b0)
            else
                stop_on_error($sformatf("mismatch at %0t: write-back enabled during reset",
                                        $time));
        end
        rst  = 1'b0;
        inst = '0;  // nop until the table starts

        // back to back with two trailing nops to drain the pipe
        for (int i = 0; i < rows.size() + 2; i++)
        begin
            @(posedge clk);
            #1;
            if (i >= 2)
                check_wb(i - 2, rows[i - 2].exp);
            else
            begin
                assert (wb.wr_en === 1'b0)  // only reset bubbles in flight
                else
                    stop_on_error($sformatf("mismatch at %0t: write-back enabled after reset",
                                            $time));
            end
            inst = (i < rows.size()) ? rows[i].inst : '0;
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: tb.f
verilog/cpu_pkg.sv
verilog/inst_decoder.sv
verilog/id_stage.sv
verilog/ex_stage.sv
verilog/regfile.sv
verilog/cpu_core.sv
testbench/cpu_core_sva.sv
testbench/tb_core.sv

// File: Makefile
SIM = obj_dir/sim_core

.PHONY: build run clean

build:
	verilator --binary --timing --assert --top-module tb_core -f tb.f -o sim_core

# pass only if the log holds the pass line
run: build
	./$(SIM) 2>&1 | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
